// File: project.f
+incdir+include
hdl/mem_subsys_pkg.sv
hdl/mem_fabric.sv
hdl/mrom.sv
hdl/sram_emc.sv
hdl/mem_subsys_top.sv
dv/mem_subsys_checker.sv
dv/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
RTL_TOP   ?= mem_subsys_top
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) +incdir+include \
		hdl/mem_subsys_pkg.sv hdl/mem_fabric.sv hdl/mrom.sv \
		hdl/sram_emc.sv hdl/mem_subsys_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mem_subsys_tb.sv
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module mem_subsys_tb;
	import mem_subsys_pkg::*;

	// Worst-case cycles of one access including SRAM timing, responder delay and stalls
	localparam int ACCESS_CYCLES = 24;
	localparam int NUM_ACCESSES  = 16 + 2 + 24 + 12 + 3 + 24;
	localparam int CYCLE_LIMIT   = 2 * (NUM_ACCESSES * ACCESS_CYCLES + 10);

	logic clk, i_reset, i_cmd_valid, i_rsp_ready, o_cmd_ready, o_rsp_valid;
	icb_cmd_t i_cmd, o_sys_cmd, sys_last_wr;
	icb_rsp_t o_rsp, i_sys_rsp;
	logic o_sys_cmd_valid, i_sys_cmd_ready, i_sys_rsp_valid, o_sys_rsp_ready;
	logic o_sram_cen, o_sram_oen, o_sram_wen, o_sram_dq_oe;
	logic [1:0] o_sram_ben;
	logic [`SRAM_AW-1:0] o_sram_a;
	logic [`SRAM_DW-1:0] o_sram_dq_o, i_sram_dq_i;
	logic [15:0] sram_mem [512];
	logic [31:0] sram_model [256];
	int pass_cnt, fail_cnt, cycles;
	bit test_err;

	mem_subsys_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run exceeded %0d cycles without finishing", CYCLE_LIMIT);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// SRAM pin model and system-memory responder
	////////////////////////////////////////////////////////////////////////////

	// The SRAM drives data only while the controller leaves the bus undriven
	assign i_sram_dq_i = (!o_sram_oen && !o_sram_dq_oe) ? sram_mem[o_sram_a[8:0]] : 16'h0;

	// Writes see data only while the controller drives the bus
	always @(posedge clk) begin
		if (!o_sram_cen && !o_sram_wen && o_sram_dq_oe) begin
			if (!o_sram_ben[0]) sram_mem[o_sram_a[8:0]][7:0] <= o_sram_dq_o[7:0];
			if (!o_sram_ben[1]) sram_mem[o_sram_a[8:0]][15:8] <= o_sram_dq_o[15:8];
		end
	end

	initial begin
		icb_cmd_t req;
		int delay;
		i_sys_cmd_ready = 1'b1;
		i_sys_rsp_valid = 1'b0;
		i_sys_rsp = '0;
		forever begin
			@(posedge clk);
			if (!i_reset && o_sys_cmd_valid && i_sys_cmd_ready) begin
				req = o_sys_cmd;
				if (!req.read) sys_last_wr = req;
				@(negedge clk);
				i_sys_cmd_ready = 1'b0;
				delay = $urandom_range(1, 4);
				repeat (delay - 1) @(negedge clk);
				i_sys_rsp_valid = 1'b1;
				i_sys_rsp = '{err: 1'b0, rdata: req.addr ^ 32'hCAFE_0000};
				do @(posedge clk); while (!o_sys_rsp_ready);
				@(negedge clk);
				i_sys_rsp_valid = 1'b0;
				i_sys_cmd_ready = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Expected values and bus access
	////////////////////////////////////////////////////////////////////////////

	// Each byte of ROM word n holds n before the seed is applied
	function automatic logic [31:0] rom_word(input logic [31:0] addr);
		int idx;
		idx = (addr >> 2) % `MROM_DEPTH;
		return {4{8'(idx)}} ^ `MROM_SEED;
	endfunction

	// Initial SRAM halfword contents
	function automatic logic [15:0] fill_half(input int a);
		return 16'(a) ^ 16'h5A3C;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] wdata, input logic [3:0] mask);
		logic [31:0] res;
		res = old;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) res[8*b +: 8] = wdata[8*b +: 8];
		end
		return res;
	endfunction

	task automatic check_rsp(input string name, input icb_rsp_t exp, input icb_rsp_t got);
		assert (got == exp) else begin
			$display("MISMATCH %s expected %h actual %h", name, exp, got);
			test_err = 1'b1;
		end
	endtask

	// Send one command and collect its response
	// With stall set, ready stays low for a random stretch
	task automatic run_access(input icb_cmd_t cmd, input bit stall, output icb_rsp_t rsp);
		int stretch;
		stretch = stall ? $urandom_range(1, 5) : 0;
		@(negedge clk);
		i_cmd_valid = 1'b1;
		i_cmd = cmd;
		do @(posedge clk); while (!o_cmd_ready);
		forever begin
			@(negedge clk);
			i_cmd_valid = 1'b0;
			i_rsp_ready = (stretch == 0);
			@(posedge clk);
			if (o_rsp_valid && i_rsp_ready) break;
			if (o_rsp_valid && stretch > 0) stretch--;
		end
		rsp = o_rsp;
		@(negedge clk);
		i_rsp_ready = 1'b1;
	endtask

	task automatic finish_test(input string name);
		$display("%-12s %s", name, test_err ? "FAIL" : "PASS");
		if (test_err) fail_cnt++;
		else pass_cnt++;
		test_err = 1'b0;
	endtask

	// Random command of a given kind with its expected response
	task automatic make_cmd(input int kind, output icb_cmd_t c, output icb_rsp_t e);
		int w;
		c = '{addr: 32'h0, read: 1'b1, wdata: $urandom, wmask: 4'hF};
		case (kind)
			0: begin
				c.addr = `MROM_BASE + ($urandom_range(0, 1023) << 2);
				e = '{err: 1'b0, rdata: rom_word(c.addr)};
			end
			1: begin
				w = $urandom_range(0, 255);
				c.addr = `SRAM_BASE + (w << 2);
				e = '{err: 1'b0, rdata: sram_model[w]};
			end
			2: begin
				c.addr = `SYSMEM_BASE + ($urandom & 32'h7FFF_FFFC);
				e = '{err: 1'b0, rdata: c.addr ^ 32'hCAFE_0000};
			end
			default: begin
				c.addr = 32'h2000_0000 + ($urandom & 32'h0FFF_FFFC);
				e = '{err: 1'b1, rdata: '0};
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		icb_cmd_t c;
		icb_rsp_t r, e;
		int w;
		int words [12];
		void'($urandom(32'h5fc9_0313));
		for (int i = 0; i < 512; i++) sram_mem[i] = fill_half(i);
		for (int i = 0; i < 256; i++) sram_model[i] = {fill_half(2*i + 1), fill_half(2*i)};
		{pass_cnt, fail_cnt, cycles, test_err} = '0;
		i_reset = 1'b1;
		i_cmd_valid = 1'b0;
		i_cmd = '0;
		i_rsp_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		i_reset = 1'b0;

		for (int i = 0; i < 16; i++) begin
			make_cmd(0, c, e);
			run_access(c, 1'b0, r);
			check_rsp("rom_read", e, r);
		end
		finish_test("rom_read");

		for (int i = 0; i < 2; i++) begin
			make_cmd(0, c, e);
			c.read = 1'b0;
			run_access(c, 1'b0, r);
			check_rsp("rom_write", '{err: 1'b1, rdata: '0}, r);
		end
		finish_test("rom_write");

		for (int i = 0; i < 12; i++) begin
			words[i] = $urandom_range(0, 255);
			c = '{addr: `SRAM_BASE + (words[i] << 2), read: 1'b0,
				wdata: $urandom, wmask: 4'($urandom)};
			sram_model[words[i]] = merge_bytes(sram_model[words[i]], c.wdata, c.wmask);
			run_access(c, 1'b0, r);
			check_rsp("sram_write", '{err: 1'b0, rdata: '0}, r);
		end
		for (int i = 0; i < 12; i++) begin
			w = words[i];
			c = '{addr: `SRAM_BASE + (w << 2), read: 1'b1, wdata: '0, wmask: '0};
			run_access(c, 1'b0, r);
			check_rsp("sram_read", '{err: 1'b0, rdata: sram_model[w]}, r);
		end
		finish_test("sram_rw");

		for (int i = 0; i < 12; i++) begin
			make_cmd(2, c, e);
			c.read = (i % 3 != 0);
			run_access(c, 1'b0, r);
			check_rsp("sysmem", e, r);
			if (!c.read) begin
				assert (sys_last_wr == c) else begin
					$display("MISMATCH sysmem_wr expected %h actual %h", c, sys_last_wr);
					test_err = 1'b1;
				end
			end
		end
		finish_test("sysmem");

		for (int i = 0; i < 3; i++) begin
			make_cmd(3, c, e);
			run_access(c, 1'b0, r);
			check_rsp("unmapped", e, r);
		end
		finish_test("unmapped");

		for (int i = 0; i < 24; i++) begin
			make_cmd($urandom_range(0, 3), c, e);
			run_access(c, 1'b1, r);
			check_rsp("backpressure", e, r);
		end
		finish_test("backpressure");

		$display("Tests passed %0d, failed %0d, assertion errors %0d",
			pass_cnt, fail_cnt, DUT.u_checker.err_cnt);
		if (fail_cnt == 0 && DUT.u_checker.err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

// File: dv/mem_subsys_checker.sv
`timescale 1ns/1ns

module mem_subsys_checker (
	input logic                     clk,
	input logic                     i_reset,
	input logic                     i_cmd_valid,
	input logic                     o_cmd_ready,
	input logic                     o_rsp_valid,
	input mem_subsys_pkg::icb_rsp_t o_rsp,
	input logic                     i_rsp_ready,
	input logic                     o_sram_cen,
	input logic                     o_sram_oen,
	input logic                     o_sram_wen
);
	import mem_subsys_pkg::*;

	int   err_stable, err_ready, err_strobe, err_cen;
	int   err_cnt;
	logic pending;

	assign err_cnt = err_stable + err_ready + err_strobe + err_cen;

	// Accepted command whose response has not transferred yet
	always_ff @(posedge clk) begin
		if (i_reset) begin
			pending <= 1'b0;
		end else if (i_cmd_valid && o_cmd_ready) begin
			pending <= 1'b1;
		end else if (o_rsp_valid && i_rsp_ready) begin
			pending <= 1'b0;
		end
	end

	a_rsp_stable: assert property (@(posedge clk) disable iff (i_reset)
		(o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)))
		else begin
			$error("Response changed or dropped under back-pressure");
			err_stable++;
		end

	a_one_outstanding: assert property (@(posedge clk) disable iff (i_reset)
		pending |-> !o_cmd_ready)
		else begin
			$error("Command ready while a response is pending");
			err_ready++;
		end

	a_strobe_excl: assert property (@(posedge clk) disable iff (i_reset)
		!(!o_sram_wen && !o_sram_oen))
		else begin
			$error("SRAM write and output enables low together");
			err_strobe++;
		end

	a_strobe_cen: assert property (@(posedge clk) disable iff (i_reset)
		o_sram_cen |-> (o_sram_wen && o_sram_oen))
		else begin
			$error("SRAM strobe low while chip enable is high");
			err_cen++;
		end

endmodule

bind mem_subsys_top mem_subsys_checker u_checker (
	.clk         (clk),
	.i_reset     (i_reset),
	.i_cmd_valid (i_cmd_valid),
	.o_cmd_ready (o_cmd_ready),
	.o_rsp_valid (o_rsp_valid),
	.o_rsp       (o_rsp),
	.i_rsp_ready (i_rsp_ready),
	.o_sram_cen  (o_sram_cen),
	.o_sram_oen  (o_sram_oen),
	.o_sram_wen  (o_sram_wen)
);

// File: hdl/mem_subsys_top.sv
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module mem_subsys_top (
	input  logic                     clk,
	input  logic                     i_reset,
	// Memory bus from the core
	input  logic                     i_cmd_valid,
	input  mem_subsys_pkg::icb_cmd_t i_cmd,
	output logic                     o_cmd_ready,
	output logic                     o_rsp_valid,
	output mem_subsys_pkg::icb_rsp_t o_rsp,
	input  logic                     i_rsp_ready,
	// System memory port
	output logic                     o_sys_cmd_valid,
	output mem_subsys_pkg::icb_cmd_t o_sys_cmd,
	input  logic                     i_sys_cmd_ready,
	input  logic                     i_sys_rsp_valid,
	input  mem_subsys_pkg::icb_rsp_t i_sys_rsp,
	output logic                     o_sys_rsp_ready,
	// SRAM pins
	output logic                     o_sram_cen,
	output logic                     o_sram_oen,
	output logic                     o_sram_wen,
	output logic [1:0]               o_sram_ben,
	output logic [`SRAM_AW-1:0]      o_sram_a,
	output logic [`SRAM_DW-1:0]      o_sram_dq_o,
	output logic                     o_sram_dq_oe,
	input  logic [`SRAM_DW-1:0]      i_sram_dq_i
);
	import mem_subsys_pkg::*;

	// Fabric to mask ROM
	logic     mrom_cmd_valid;
	icb_cmd_t mrom_cmd;
	logic     mrom_cmd_ready;
	logic     mrom_rsp_valid;
	icb_rsp_t mrom_rsp;
	logic     mrom_rsp_ready;

	// Fabric to SRAM controller
	logic     sram_cmd_valid;
	icb_cmd_t sram_cmd;
	logic     sram_cmd_ready;
	logic     sram_rsp_valid;
	icb_rsp_t sram_rsp;
	logic     sram_rsp_ready;

	////////////////////////////////////////////////////////////////////////////
	// Fabric and targets
	////////////////////////////////////////////////////////////////////////////

	mem_fabric u_fabric (
		.clk              (clk),
		.i_reset          (i_reset),
		.i_cmd_valid      (i_cmd_valid),
		.i_cmd            (i_cmd),
		.o_cmd_ready      (o_cmd_ready),
		.o_rsp_valid      (o_rsp_valid),
		.o_rsp            (o_rsp),
		.i_rsp_ready      (i_rsp_ready),
		.o_mrom_cmd_valid (mrom_cmd_valid),
		.o_mrom_cmd       (mrom_cmd),
		.i_mrom_cmd_ready (mrom_cmd_ready),
		.i_mrom_rsp_valid (mrom_rsp_valid),
		.i_mrom_rsp       (mrom_rsp),
		.o_mrom_rsp_ready (mrom_rsp_ready),
		.o_sram_cmd_valid (sram_cmd_valid),
		.o_sram_cmd       (sram_cmd),
		.i_sram_cmd_ready (sram_cmd_ready),
		.i_sram_rsp_valid (sram_rsp_valid),
		.i_sram_rsp       (sram_rsp),
		.o_sram_rsp_ready (sram_rsp_ready),
		.o_sys_cmd_valid  (o_sys_cmd_valid),
		.o_sys_cmd        (o_sys_cmd),
		.i_sys_cmd_ready  (i_sys_cmd_ready),
		.i_sys_rsp_valid  (i_sys_rsp_valid),
		.i_sys_rsp        (i_sys_rsp),
		.o_sys_rsp_ready  (o_sys_rsp_ready)
	);

	mrom u_mrom (
		.clk         (clk),
		.i_reset     (i_reset),
		.i_cmd_valid (mrom_cmd_valid),
		.i_cmd       (mrom_cmd),
		.o_cmd_ready (mrom_cmd_ready),
		.o_rsp_valid (mrom_rsp_valid),
		.o_rsp       (mrom_rsp),
		.i_rsp_ready (mrom_rsp_ready)
	);

	sram_emc u_sram_emc (
		.clk          (clk),
		.i_reset      (i_reset),
		.i_cmd_valid  (sram_cmd_valid),
		.i_cmd        (sram_cmd),
		.o_cmd_ready  (sram_cmd_ready),
		.o_rsp_valid  (sram_rsp_valid),
		.o_rsp        (sram_rsp),
		.i_rsp_ready  (sram_rsp_ready),
		.o_sram_cen   (o_sram_cen),
		.o_sram_oen   (o_sram_oen),
		.o_sram_wen   (o_sram_wen),
		.o_sram_ben   (o_sram_ben),
		.o_sram_a     (o_sram_a),
		.o_sram_dq_o  (o_sram_dq_o),
		.o_sram_dq_oe (o_sram_dq_oe),
		.i_sram_dq_i  (i_sram_dq_i)
	);

endmodule

// File: hdl/sram_emc.sv
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module sram_emc (
	input  logic                     clk,
	input  logic                     i_reset,
	input  logic                     i_cmd_valid,
	input  mem_subsys_pkg::icb_cmd_t i_cmd,
	output logic                     o_cmd_ready,
	output logic                     o_rsp_valid,
	output mem_subsys_pkg::icb_rsp_t o_rsp,
	input  logic                     i_rsp_ready,
	// SRAM pins, strobes active low
	output logic                     o_sram_cen,
	output logic                     o_sram_oen,
	output logic                     o_sram_wen,
	output logic [1:0]               o_sram_ben,
	output logic [`SRAM_AW-1:0]      o_sram_a,
	output logic [`SRAM_DW-1:0]      o_sram_dq_o,
	output logic                     o_sram_dq_oe,
	input  logic [`SRAM_DW-1:0]      i_sram_dq_i
);
	import mem_subsys_pkg::*;

	localparam int CNT_W = $clog2(`SRAM_ACCESS_CYCLES + 1);

	sram_state_e        state_q;
	sram_state_e        state_d;
	logic [CNT_W-1:0]   cnt_q;
	logic               cnt_last;
	logic               active;
	logic               hi_half;
	logic [1:0]         mask_half;
	icb_cmd_t           cmd_q;
	logic [`MEM_DW-1:0] rdata_q;

	assign cnt_last = (cnt_q == CNT_W'(`SRAM_ACCESS_CYCLES - 1));
	assign active   = (state_q == ST_LO) || (state_q == ST_HI);
	assign hi_half  = (state_q == ST_HI);

	////////////////////////////////////////////////////////////////////////////
	// Access sequencing
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (i_cmd_valid) begin
					state_d = ST_LO;
				end
			end
			ST_LO: begin
				if (cnt_last) begin
					state_d = ST_HI;
				end
			end
			ST_HI: begin
				if (cnt_last) begin
					state_d = ST_RSP;
				end
			end
			default: begin
				if (i_rsp_ready) begin
					state_d = ST_IDLE;
				end
			end
		endcase
	end

	// Strobe counter restarts for each halfword
	always_ff @(posedge clk) begin
		if (i_reset) begin
			state_q <= ST_IDLE;
			cnt_q   <= '0;
		end else begin
			state_q <= state_d;
			if (active && !cnt_last) begin
				cnt_q <= cnt_q + CNT_W'(1);
			end else begin
				cnt_q <= '0;
			end
		end
	end

	// Latch the command, then assemble read data half by half
	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && i_cmd_valid) begin
			cmd_q   <= i_cmd;
			rdata_q <= '0;
		end
		if (active && cnt_last && cmd_q.read) begin
			if (hi_half) begin
				rdata_q[`SRAM_DW +: `SRAM_DW] <= i_sram_dq_i;
			end else begin
				rdata_q[0 +: `SRAM_DW] <= i_sram_dq_i;
			end
		end
	end

	assign o_cmd_ready = (state_q == ST_IDLE);
	assign o_rsp_valid = (state_q == ST_RSP);
	assign o_rsp       = '{err: 1'b0, rdata: rdata_q};

	////////////////////////////////////////////////////////////////////////////
	// SRAM pins
	////////////////////////////////////////////////////////////////////////////

	assign mask_half = hi_half ? cmd_q.wmask[3:2] : cmd_q.wmask[1:0];

	assign o_sram_cen   = !active;
	assign o_sram_oen   = !(active && cmd_q.read);
	assign o_sram_wen   = !(active && !cmd_q.read);
	assign o_sram_dq_oe = active && !cmd_q.read;

	// Reads enable both bytes, idle leaves them off
	assign o_sram_ben = !active ? 2'b11 : (cmd_q.read ? 2'b00 : ~mask_half);

	// Halfword address, low half at the even slot
	assign o_sram_a    = {cmd_q.addr[`SRAM_AW:2], hi_half};
	assign o_sram_dq_o = hi_half ? cmd_q.wdata[`SRAM_DW +: `SRAM_DW]
		: cmd_q.wdata[0 +: `SRAM_DW];

endmodule

// File: hdl/mrom.sv
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module mrom (
	input  logic                     clk,
	input  logic                     i_reset,
	input  logic                     i_cmd_valid,
	input  mem_subsys_pkg::icb_cmd_t i_cmd,
	output logic                     o_cmd_ready,
	output logic                     o_rsp_valid,
	output mem_subsys_pkg::icb_rsp_t o_rsp,
	input  logic                     i_rsp_ready
);
	import mem_subsys_pkg::*;

	localparam int IDX_W = $clog2(`MROM_DEPTH);

	logic [`MEM_DW-1:0] rom_mem [`MROM_DEPTH];
	logic [IDX_W-1:0]   rd_idx;
	logic               cmd_fire;

	// Contents fixed by rule
	for (genvar n = 0; n < `MROM_DEPTH; n++) begin : g_rom
		assign rom_mem[n] = (`MEM_DW'(n) * `MROM_STEP) ^ `MROM_SEED;
	end

	// Word offset wraps at the ROM depth
	assign rd_idx = i_cmd.addr[2 +: IDX_W];

	// No new command while a response waits
	assign o_cmd_ready = !o_rsp_valid;
	assign cmd_fire    = i_cmd_valid && o_cmd_ready;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_rsp_valid <= 1'b0;
		end else if (cmd_fire) begin
			o_rsp_valid <= 1'b1;
		end else if (i_rsp_ready) begin
			o_rsp_valid <= 1'b0;
		end
	end

	// Writes to ROM come back as errors
	always_ff @(posedge clk) begin
		if (cmd_fire) begin
			o_rsp.err   <= !i_cmd.read;
			o_rsp.rdata <= i_cmd.read ? rom_mem[rd_idx] : '0;
		end
	end

endmodule

// File: hdl/mem_fabric.sv
`timescale 1ns/1ns
`include "mem_subsys_cfg.svh"

module mem_fabric (
	input  logic                     clk,
	input  logic                     i_reset,
	input  logic                     i_cmd_valid,
	input  mem_subsys_pkg::icb_cmd_t i_cmd,
	output logic                     o_cmd_ready,
	output logic                     o_rsp_valid,
	output mem_subsys_pkg::icb_rsp_t o_rsp,
	input  logic                     i_rsp_ready,
	// Mask ROM
	output logic                     o_mrom_cmd_valid,
	output mem_subsys_pkg::icb_cmd_t o_mrom_cmd,
	input  logic                     i_mrom_cmd_ready,
	input  logic                     i_mrom_rsp_valid,
	input  mem_subsys_pkg::icb_rsp_t i_mrom_rsp,
	output logic                     o_mrom_rsp_ready,
	// External SRAM controller
	output logic                     o_sram_cmd_valid,
	output mem_subsys_pkg::icb_cmd_t o_sram_cmd,
	input  logic                     i_sram_cmd_ready,
	input  logic                     i_sram_rsp_valid,
	input  mem_subsys_pkg::icb_rsp_t i_sram_rsp,
	output logic                     o_sram_rsp_ready,
	// System memory port
	output logic                     o_sys_cmd_valid,
	output mem_subsys_pkg::icb_cmd_t o_sys_cmd,
	input  logic                     i_sys_cmd_ready,
	input  logic                     i_sys_rsp_valid,
	input  mem_subsys_pkg::icb_rsp_t i_sys_rsp,
	output logic                     o_sys_rsp_ready
);
	import mem_subsys_pkg::*;

	mem_target_e dec_tgt;
	mem_target_e busy_tgt;
	logic        busy;
	logic        tgt_ready;
	logic        cmd_fire;
	logic        rsp_fire;

	function automatic logic in_region(input logic [`MEM_AW-1:0] addr,
			input logic [`MEM_AW-1:0] base, input int lsb);
		return (addr >> lsb) == (base >> lsb);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Address decode and command steering
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		if (in_region(i_cmd.addr, `MROM_BASE, `MROM_LSB)) begin
			dec_tgt = TGT_MROM;
		end else if (in_region(i_cmd.addr, `SRAM_BASE, `SRAM_LSB)) begin
			dec_tgt = TGT_SRAM;
		end else if (in_region(i_cmd.addr, `SYSMEM_BASE, `SYSMEM_LSB)) begin
			dec_tgt = TGT_SYSMEM;
		end else begin
			dec_tgt = TGT_NONE;
		end
	end

	// Unmapped commands are always taken
	always_comb begin
		case (dec_tgt)
			TGT_MROM:   tgt_ready = i_mrom_cmd_ready;
			TGT_SRAM:   tgt_ready = i_sram_cmd_ready;
			TGT_SYSMEM: tgt_ready = i_sys_cmd_ready;
			default:    tgt_ready = 1'b1;
		endcase
	end

	// Only one transaction in flight
	assign o_cmd_ready = !busy && tgt_ready;
	assign cmd_fire    = i_cmd_valid && o_cmd_ready;

	assign o_mrom_cmd_valid = i_cmd_valid && !busy && (dec_tgt == TGT_MROM);
	assign o_sram_cmd_valid = i_cmd_valid && !busy && (dec_tgt == TGT_SRAM);
	assign o_sys_cmd_valid  = i_cmd_valid && !busy && (dec_tgt == TGT_SYSMEM);

	assign o_mrom_cmd = i_cmd;
	assign o_sram_cmd = i_cmd;
	assign o_sys_cmd  = i_cmd;

	////////////////////////////////////////////////////////////////////////////
	// Response return
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		o_rsp_valid = 1'b0;
		o_rsp       = '0;
		if (busy) begin
			case (busy_tgt)
				TGT_MROM: begin
					o_rsp_valid = i_mrom_rsp_valid;
					o_rsp       = i_mrom_rsp;
				end
				TGT_SRAM: begin
					o_rsp_valid = i_sram_rsp_valid;
					o_rsp       = i_sram_rsp;
				end
				TGT_SYSMEM: begin
					o_rsp_valid = i_sys_rsp_valid;
					o_rsp       = i_sys_rsp;
				end
				default: begin
					// Error for a hole in the map, one cycle after accept
					o_rsp_valid = 1'b1;
					o_rsp       = '{err: 1'b1, rdata: '0};
				end
			endcase
		end
	end

	assign rsp_fire = o_rsp_valid && i_rsp_ready;

	assign o_mrom_rsp_ready = busy && (busy_tgt == TGT_MROM) && i_rsp_ready;
	assign o_sram_rsp_ready = busy && (busy_tgt == TGT_SRAM) && i_rsp_ready;
	assign o_sys_rsp_ready  = busy && (busy_tgt == TGT_SYSMEM) && i_rsp_ready;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy     <= 1'b0;
			busy_tgt <= TGT_NONE;
		end else if (cmd_fire) begin
			busy     <= 1'b1;
			busy_tgt <= dec_tgt;
		end else if (rsp_fire) begin
			busy <= 1'b0;
		end
	end

endmodule

// File: hdl/mem_subsys_pkg.sv
`include "mem_subsys_cfg.svh"

package mem_subsys_pkg;

	// Command channel payload
	typedef struct packed {
		logic [`MEM_AW-1:0]   addr;
		logic                 read;
		logic [`MEM_DW-1:0]   wdata;
		logic [`MEM_DW/8-1:0] wmask;
	} icb_cmd_t;

	// Response channel payload
	typedef struct packed {
		logic               err;
		logic [`MEM_DW-1:0] rdata;
	} icb_rsp_t;

	// Decoded fabric target
	// TGT_NONE is answered by the fabric itself
	typedef enum logic [1:0] {
		TGT_MROM,
		TGT_SRAM,
		TGT_SYSMEM,
		TGT_NONE
	} mem_target_e;

	// SRAM controller states
	// Low halfword first, then high halfword, then hold the response
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LO,
		ST_HI,
		ST_RSP
	} sram_state_e;

endpackage

// File: include/mem_subsys_cfg.svh
`ifndef MEM_SUBSYS_CFG_SVH
`define MEM_SUBSYS_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Mask width is MEM_DW/8
`define MEM_AW 32
`define MEM_DW 32

// External asynchronous SRAM, 16-bit wide
`define SRAM_AW 22
`define SRAM_DW 16

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Mask ROM, 0x0000_1000 to 0x0000_1FFF
`define MROM_BASE 32'h0000_1000
`define MROM_LSB 12

// External SRAM, 0x4000_0000 to 0x4FFF_FFFF
`define SRAM_BASE 32'h4000_0000
`define SRAM_LSB 28

// System memory, upper half of the space
`define SYSMEM_BASE 32'h8000_0000
`define SYSMEM_LSB 31

////////////////////////////////////////////////////////////////////////////
// Target parameters
////////////////////////////////////////////////////////////////////////////

// ROM word n holds n * MROM_STEP ^ MROM_SEED
`define MROM_DEPTH 64
`define MROM_SEED 32'h1357_9BDF
`define MROM_STEP 32'h0101_0101

// Cycles each halfword access holds its strobes
`define SRAM_ACCESS_CYCLES 2

`endif
